//--- hw/game_defs.svh
// screen bounds, sizes, physics constants and colours of the platform game
// include wherever one of these values is needed
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// horizontal limits for the hero
`define SCREEN_LEFT    143
`define SCREEN_RIGHT   734

// object sizes in pixels
`define HERO_SIZE      32
`define TILE_SIZE      24
`define COIN_SIZE      16

// ground band on screen
`define GROUND_Y       460
`define GROUND_BOTTOM  516

// hero start column
`define HERO_X_INIT    300

// jump speed and gravity, in pixels per step
`define V_INIT         15
`define GRAVITY        1

// extra depth a platform top accepts when the hero lands on it
`define LAND_TOL       20

`define SKY_RGB        12'h7AF
`define GROUND_RGB     12'h952
`define PLATFORM_RGB   12'hC73
`define HERO_RGB       12'hE11
// coin shimmer, dark to light
`define COIN_RGB0      12'hA80
`define COIN_RGB1      12'hDB1
`define COIN_RGB2      12'hFF7

// per-map table sizes
`define NUM_PLATFORMS  6
`define NUM_COINS      4

`endif

//--- hw/game_pkg.sv
// shared types, map tables and hero overlap rules of the game
// imported by the game state, the renderer and the top level
`default_nettype none

`include "game_defs.svh"

package game_pkg;

    typedef logic [9:0] coord_t;
    typedef logic signed [6:0] vel_t;
    typedef logic [11:0] rgb_t;

    typedef enum logic [2:0] {
        PIX_BLANK,
        PIX_SKY,
        PIX_GROUND,
        PIX_PLATFORM,
        PIX_COIN,
        PIX_HERO
    } pix_class_t;

    typedef logic [`NUM_COINS-1:0] coin_mask_t;

    typedef struct packed {
        coord_t x_start;
        coord_t x_end;
        coord_t y;
    } platform_t;

    localparam int NUM_MAPS = 2;

    localparam platform_t PLATFORMS [NUM_MAPS][`NUM_PLATFORMS] = '{
        '{
            '{10'd500, 10'd540, 10'd400},
            '{10'd250, 10'd290, 10'd300},
            '{10'd600, 10'd640, 10'd400},
            '{10'd350, 10'd450, 10'd350},
            '{10'(`SCREEN_LEFT), 10'd200, 10'd250},
            '{10'd400, 10'd500, 10'd250}
        },
        '{
            '{10'd600, 10'd640, 10'd400},
            '{10'd400, 10'd540, 10'd340},
            '{10'd540, 10'd700, 10'd240},
            '{10'd430, 10'd470, 10'd200},
            '{10'd250, 10'd400, 10'd200},
            '{10'd250, 10'd300, 10'd300}
        }
    };

    // top left corner of each coin, coin 3 rests on the ground
    localparam coord_t COIN_X [NUM_MAPS][`NUM_COINS] = '{
        '{10'd400, 10'd250, 10'd600, 10'd360},
        '{10'd620, 10'd280, 10'd430, 10'd240}
    };
    localparam coord_t COIN_Y [NUM_MAPS][`NUM_COINS] = '{
        '{10'd184, 10'd284, 10'd384, 10'd444},
        '{10'd384, 10'd284, 10'd184, 10'd444}
    };

    // either hero edge strictly inside the platform span
    function automatic logic spans_x(platform_t p, coord_t x);
        return ((x + `HERO_SIZE > p.x_start) && (x + `HERO_SIZE < p.x_end)) ||
               ((x > p.x_start) && (x < p.x_end));
    endfunction

    function automatic logic hero_hits_side(logic map, coord_t x, coord_t y);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            if (spans_x(PLATFORMS[map][i], x) &&
                (y + `HERO_SIZE > PLATFORMS[map][i].y) &&
                (y < PLATFORMS[map][i].y + `TILE_SIZE)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // top of the hero inside the underside band of a platform
    function automatic logic hero_hits_head(logic map, coord_t x, coord_t y);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            if (spans_x(PLATFORMS[map][i], x) &&
                (y <= PLATFORMS[map][i].y + `TILE_SIZE) &&
                (y > PLATFORMS[map][i].y)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic hero_on_platform(logic map, coord_t x, coord_t y);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            if (spans_x(PLATFORMS[map][i], x) &&
                (y + `HERO_SIZE >= PLATFORMS[map][i].y) &&
                (y + `HERO_SIZE <= PLATFORMS[map][i].y + `LAND_TOL)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // top of the supporting platform, the ground top when there is none
    function automatic coord_t platform_top_under(logic map, coord_t x, coord_t y);
        coord_t top;
        top = coord_t'(`GROUND_Y);
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            if (spans_x(PLATFORMS[map][i], x) &&
                (y + `HERO_SIZE >= PLATFORMS[map][i].y) &&
                (y + `HERO_SIZE <= PLATFORMS[map][i].y + `LAND_TOL)) begin
                top = PLATFORMS[map][i].y;
            end
        end
        return top;
    endfunction

    function automatic logic hero_touches_coin(logic map, int idx, coord_t x, coord_t y);
        return !((x + `HERO_SIZE <= COIN_X[map][idx]) ||
                 (x >= COIN_X[map][idx] + `COIN_SIZE) ||
                 (y + `HERO_SIZE <= COIN_Y[map][idx]) ||
                 (y >= COIN_Y[map][idx] + `COIN_SIZE));
    endfunction

endpackage

`default_nettype wire

//--- hw/scene_if.sv
// scene snapshot passed from the game state to the renderer
`default_nettype none

`include "game_defs.svh"

interface scene_if
    import game_pkg::*;
();

    coord_t     hero_x;
    coord_t     hero_y;
    logic       map_sel;
    coin_mask_t coin_mask;
    // one-cycle pulse, snapshot values change on the following cycle
    logic       step;

    modport motion (output hero_x, hero_y, step, input map_sel);

    modport coins (output coin_mask, input hero_x, hero_y, map_sel, step);

    modport render (input hero_x, hero_y, map_sel, coin_mask, step);

endinterface

`default_nettype wire

//--- hw/hero_motion.sv
// hero physics, stepped once every STEP_DIV cycles
// walking, jumping, gravity and platform collisions against the current map
`default_nettype none

`include "game_defs.svh"

module hero_motion
    import game_pkg::*;
#(
    parameter int STEP_DIV = 500000
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    btn_left,
    input  logic    btn_right,
    input  logic    btn_jump,
    scene_if.motion scene
);

    localparam int CNT_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;
    localparam coord_t REST_Y = coord_t'(`GROUND_Y - `HERO_SIZE);

    logic [CNT_W-1:0] step_cnt;
    logic             step;
    logic             cnt_wrap;

    coord_t hero_x;
    coord_t hero_y;
    vel_t   speed;
    logic   jumping;

    logic   on_ground;
    logic   on_platform;
    logic   supported;
    logic   block_left;
    logic   block_right;
    coord_t land_y;

    assign cnt_wrap = (step_cnt == CNT_W'(STEP_DIV - 1));

    // step divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            step     <= 1'b0;
        end else begin
            step <= cnt_wrap;
            if (cnt_wrap) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    assign on_ground   = (hero_y + `HERO_SIZE >= `GROUND_Y);
    assign on_platform = hero_on_platform(scene.map_sel, hero_x, hero_y);
    assign supported   = on_ground || on_platform;

    // one pixel probe on either side
    assign block_left  = (hero_x <= `SCREEN_LEFT) ||
                         hero_hits_side(scene.map_sel, hero_x - 1'b1, hero_y);
    assign block_right = (hero_x + `HERO_SIZE >= `SCREEN_RIGHT) ||
                         hero_hits_side(scene.map_sel, hero_x + 1'b1, hero_y);

    // resting y once a fall ends, the ground wins over a platform
    assign land_y = on_ground ? REST_Y :
        coord_t'(platform_top_under(scene.map_sel, hero_x, hero_y) - `HERO_SIZE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hero_x  <= coord_t'(`HERO_X_INIT);
            hero_y  <= REST_Y;
            speed   <= '0;
            jumping <= 1'b0;
        end else if (step) begin
            // left has priority when both are held
            if (btn_left) begin
                if (!block_left) begin
                    hero_x <= hero_x - 1'b1;
                end
            end else if (btn_right && !block_right) begin
                hero_x <= hero_x + 1'b1;
            end

            if (jumping) begin
                if (speed < 0 && hero_hits_head(scene.map_sel, hero_x, hero_y)) begin
                    speed <= '0;
                end else if (speed > 0 && supported) begin
                    jumping <= 1'b0;
                    speed   <= '0;
                    hero_y  <= land_y;
                end else begin
                    speed  <= speed + vel_t'(`GRAVITY);
                    hero_y <= coord_t'($signed({1'b0, hero_y}) + speed);
                end
            end else if (!supported) begin
                // walked off an edge
                jumping <= 1'b1;
                speed   <= vel_t'(1);
            end else if (btn_jump) begin
                jumping <= 1'b1;
                speed   <= vel_t'(-`V_INIT);
            end
        end
    end

    assign scene.hero_x = hero_x;
    assign scene.hero_y = hero_y;
    assign scene.step   = step;

endmodule

`default_nettype wire

//--- hw/coin_tracker.sv
// collected coin flags for both maps and the score counter
// at most one coin is taken per step
`default_nettype none

`include "game_defs.svh"

module coin_tracker
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    scene_if.coins      scene,
    output logic [15:0] score
);

    localparam int IDX_W = $clog2(`NUM_COINS);

    logic [NUM_MAPS-1:0][`NUM_COINS-1:0] collected;
    coin_mask_t                          cur_mask;
    logic                                hit;
    logic [IDX_W-1:0]                    hit_idx;

    // mask of the selected map, follows map_sel at once
    assign cur_mask        = collected[scene.map_sel];
    assign scene.coin_mask = cur_mask;

    // lowest uncollected coin under the hero
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = `NUM_COINS - 1; i >= 0; i--) begin
            if (!cur_mask[i] &&
                hero_touches_coin(scene.map_sel, i, scene.hero_x, scene.hero_y)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            collected <= '0;
            score     <= '0;
        end else if (scene.step && hit) begin
            collected[scene.map_sel][hit_idx] <= 1'b1;
            score <= score + 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- hw/scene_render.sv
// two-stage pixel path, class of the scan position then its colour
// coins cycle through three shimmer colours
`default_nettype none

`include "game_defs.svh"

module scene_render
    import game_pkg::*;
#(
    parameter int SHIMMER_DIV = 10000000
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    bright,
    input  coord_t  h_count,
    input  coord_t  v_count,
    scene_if.render scene,
    output rgb_t    rgb
);

    localparam int SHIM_W = (SHIMMER_DIV > 1) ? $clog2(SHIMMER_DIV) : 1;

    logic [SHIM_W-1:0] shim_cnt;
    logic [1:0]        shim_frame;

    logic       hero_px;
    logic       ground_px;
    logic       platform_px;
    logic       coin_px;
    pix_class_t pix_class;
    pix_class_t class_q;
    rgb_t       colour;

    function automatic logic in_rect(coord_t h, coord_t v, coord_t x0, coord_t y0,
                                     int w, int ht);
        return (h >= x0) && (h < x0 + w) && (v >= y0) && (v < y0 + ht);
    endfunction

    // shimmer frame 0, 1, 2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shim_cnt   <= '0;
            shim_frame <= '0;
        end else if (shim_cnt == SHIM_W'(SHIMMER_DIV - 1)) begin
            shim_cnt   <= '0;
            shim_frame <= (shim_frame == 2'd2) ? 2'd0 : shim_frame + 2'd1;
        end else begin
            shim_cnt <= shim_cnt + 1'b1;
        end
    end

    assign hero_px = in_rect(h_count, v_count, scene.hero_x, scene.hero_y,
                             `HERO_SIZE, `HERO_SIZE);
    assign ground_px = (v_count >= `GROUND_Y) && (v_count <= `GROUND_BOTTOM);

    always_comb begin
        platform_px = 1'b0;
        coin_px     = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            if (in_rect(h_count, v_count, PLATFORMS[scene.map_sel][i].x_start,
                        PLATFORMS[scene.map_sel][i].y,
                        PLATFORMS[scene.map_sel][i].x_end -
                        PLATFORMS[scene.map_sel][i].x_start, `TILE_SIZE)) begin
                platform_px = 1'b1;
            end
        end
        for (int i = 0; i < `NUM_COINS; i++) begin
            if (!scene.coin_mask[i] &&
                in_rect(h_count, v_count, COIN_X[scene.map_sel][i],
                        COIN_Y[scene.map_sel][i], `COIN_SIZE, `COIN_SIZE)) begin
                coin_px = 1'b1;
            end
        end
    end

    // priority, hero drawn over everything
    always_comb begin
        if (!bright)          pix_class = PIX_BLANK;
        else if (hero_px)     pix_class = PIX_HERO;
        else if (ground_px)   pix_class = PIX_GROUND;
        else if (platform_px) pix_class = PIX_PLATFORM;
        else if (coin_px)     pix_class = PIX_COIN;
        else                  pix_class = PIX_SKY;
    end

    always_comb begin
        case (class_q)
            PIX_SKY:      colour = `SKY_RGB;
            PIX_GROUND:   colour = `GROUND_RGB;
            PIX_PLATFORM: colour = `PLATFORM_RGB;
            PIX_HERO:     colour = `HERO_RGB;
            PIX_COIN: begin
                case (shim_frame)
                    2'd0:    colour = `COIN_RGB0;
                    2'd1:    colour = `COIN_RGB1;
                    default: colour = `COIN_RGB2;
                endcase
            end
            default:      colour = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            class_q <= PIX_BLANK;
            rgb     <= '0;
        end else begin
            class_q <= pix_class;
            rgb     <= colour;
        end
    end

endmodule

`default_nettype wire

//--- hw/game_top.sv
// platform game pixel engine, scan position and buttons in, pixel colour out
// game state feeds the renderer through the scene interface
`default_nettype none

`include "game_defs.svh"

module game_top
    import game_pkg::*;
#(
    parameter int STEP_DIV    = 500000,
    parameter int SHIMMER_DIV = 10000000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        bright,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_jump,
    input  logic        map_sel,
    input  coord_t      h_count,
    input  coord_t      v_count,
    output rgb_t        rgb,
    output logic [15:0] score
);

    scene_if u_scene ();

    assign u_scene.map_sel = map_sel;

    hero_motion #(
        .STEP_DIV (STEP_DIV)
    ) u_hero_motion (
        .clk       (clk),
        .rst       (rst),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .scene     (u_scene)
    );

    coin_tracker u_coin_tracker (
        .clk   (clk),
        .rst   (rst),
        .scene (u_scene),
        .score (score)
    );

    scene_render #(
        .SHIMMER_DIV (SHIMMER_DIV)
    ) u_scene_render (
        .clk     (clk),
        .rst     (rst),
        .bright  (bright),
        .h_count (h_count),
        .v_count (v_count),
        .scene   (u_scene),
        .rgb     (rgb)
    );

endmodule

`default_nettype wire

//--- verification/game_checker.sv
// assertions on the game engine outputs, bound into the top level
`default_nettype none

module game_checker
    import game_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        bright,
    input rgb_t        rgb,
    input logic [15:0] score
);

    timeunit 1ns;
    timeprecision 1ps;

    // failures seen so far, read by the testbench at the end
    int assert_fails = 0;

    // outputs stay at zero while reset is held
    a_reset_zero: assert property (@(posedge clk) rst && $past(rst) |-> rgb == '0 && score == '0)
        else begin
            assert_fails++;
            $error("rgb or score not zero during reset");
        end

    a_score_no_fall: assert property (@(posedge clk) disable iff (rst) score >= $past(score))
        else begin
            assert_fails++;
            $error("score fell");
        end

    // at most one coin per step
    a_score_step: assert property (@(posedge clk) disable iff (rst)
        {1'b0, score} <= {1'b0, $past(score)} + 17'd1)
        else begin
            assert_fails++;
            $error("score rose by more than one");
        end

    a_blank: assert property (@(posedge clk) disable iff (rst) !bright |-> ##2 rgb == '0)
        else begin
            assert_fails++;
            $error("rgb not black two cycles after bright low");
        end

endmodule

`default_nettype wire

//--- verification/game_tb.sv
// testbench for the platform game pixel engine
// walks, jumps and collects coins while comparing pixels with a reference model
`default_nettype none

`include "game_defs.svh"

module game_tb
    import game_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STEP_DIV = 4;
    localparam int TIMEOUT  = 2000;

    logic        clk;
    logic        rst;
    logic        bright;
    logic        btn_left;
    logic        btn_right;
    logic        btn_jump;
    logic        map_sel;
    coord_t      h_count;
    coord_t      v_count;
    rgb_t        rgb;
    logic [15:0] score;

    // reference state of the game
    int          model_x;
    int          model_y;
    coin_mask_t  model_mask [2];
    logic [31:0] rng;
    string       test_name;

    // expected colours in flight through the pixel pipeline
    rgb_t exp_now;
    rgb_t exp_q1;
    rgb_t exp_q2;
    logic chk_now;
    logic chk_q1;
    logic chk_q2;

    game_top #(
        .STEP_DIV    (STEP_DIV),
        .SHIMMER_DIV (1000000)
    ) u_game_top (
        .clk       (clk),
        .rst       (rst),
        .bright    (bright),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .map_sel   (map_sel),
        .h_count   (h_count),
        .v_count   (v_count),
        .rgb       (rgb),
        .score     (score)
    );

    bind game_top game_checker u_checker (
        .clk    (clk),
        .rst    (rst),
        .bright (bright),
        .rgb    (rgb),
        .score  (score)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic covers(input int h, input int v, input int x0, input int y0,
                                    input int w, input int ht);
        return (h >= x0) && (h < x0 + w) && (v >= y0) && (v < y0 + ht);
    endfunction

    // expected colour by the drawing priority, shimmer frame 0
    function automatic rgb_t ref_pixel(input int h, input int v, input logic on,
                                       input logic map, input int hx, input int hy,
                                       input coin_mask_t mask);
        if (!on) begin
            return 12'h000;
        end
        if (covers(h, v, hx, hy, `HERO_SIZE, `HERO_SIZE)) begin
            return `HERO_RGB;
        end
        if (v >= `GROUND_Y && v <= `GROUND_BOTTOM) begin
            return `GROUND_RGB;
        end
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            if (covers(h, v, PLATFORMS[map][i].x_start, PLATFORMS[map][i].y,
                       PLATFORMS[map][i].x_end - PLATFORMS[map][i].x_start, `TILE_SIZE)) begin
                return `PLATFORM_RGB;
            end
        end
        for (int i = 0; i < `NUM_COINS; i++) begin
            if (!mask[i] && covers(h, v, COIN_X[map][i], COIN_Y[map][i],
                                   `COIN_SIZE, `COIN_SIZE)) begin
                return `COIN_RGB0;
            end
        end
        return `SKY_RGB;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: expected %0h, actual %0h",
                                        name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // lowest uncollected coin under the hero becomes collected
    task automatic mark_coin(input logic map, input int x, input int y);
        int taken;
        taken = -1;
        for (int i = `NUM_COINS - 1; i >= 0; i--) begin
            if (!model_mask[map][i] &&
                x < COIN_X[map][i] + `COIN_SIZE && COIN_X[map][i] < x + `HERO_SIZE &&
                y < COIN_Y[map][i] + `COIN_SIZE && COIN_Y[map][i] < y + `HERO_SIZE) begin
                taken = i;
            end
        end
        if (taken < 0) begin
            stop_with_failure($sformatf("reference model finds no coin under hero x %0d", x));
        end else begin
            model_mask[map][taken] = 1'b1;
        end
    endtask

    task automatic drive_pixel(input int h, input int v, input logic on, input logic map);
        h_count = coord_t'(h);
        v_count = coord_t'(v);
        bright  = on;
        map_sel = map;
        exp_now = ref_pixel(h, v, on, map, model_x, model_y, model_mask[map]);
        chk_now = 1'b1;
        next_cycle();
    endtask

    // let the last expected colours leave the pipeline
    task automatic drain_pixels();
        chk_now = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic check_scene(input string name, input int count);
        int h;
        int v;
        test_name = name;
        for (int m = 0; m < 2; m++) begin
            // a few fixed pixels so every class appears on each map
            drive_pixel(model_x + 5, model_y + 5, 1'b1, m[0]);
            drive_pixel(400, 480, 1'b1, m[0]);
            drive_pixel(700, 100, 1'b1, m[0]);
            for (int i = 0; i < `NUM_PLATFORMS; i++) begin
                drive_pixel(PLATFORMS[m][i].x_start + 1, PLATFORMS[m][i].y + 1, 1'b1, m[0]);
            end
            for (int i = 0; i < `NUM_COINS; i++) begin
                drive_pixel(COIN_X[m][i] + 8, COIN_Y[m][i] + 8, 1'b1, m[0]);
            end
            for (int n = 0; n < count; n++) begin
                rng = xorshift(rng);
                h   = int'(rng % 32'd800);
                v   = int'((rng >> 12) % 32'd525);
                drive_pixel(h, v, rng[31:29] != 3'b000, m[0]);
            end
        end
        drain_pixels();
    endtask

    task automatic wait_for_hero(input string what, input int h, input int v,
                                 input logic want);
        int n;
        h_count = coord_t'(h);
        v_count = coord_t'(v);
        bright  = 1'b1;
        repeat (2) next_cycle();
        n = 0;
        while ((rgb == `HERO_RGB) != want) begin
            if (n >= TIMEOUT) begin
                stop_with_failure(what);
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_for_score(input string what, input logic [15:0] target);
        int n;
        n = 0;
        while (score != target) begin
            if (n >= TIMEOUT) begin
                stop_with_failure(what);
            end
            next_cycle();
            n++;
        end
    endtask

    always @(posedge clk) begin
        chk_q1 <= chk_now;
        exp_q1 <= exp_now;
        chk_q2 <= chk_q1;
        exp_q2 <= exp_q1;
    end

    // rgb settles after the edge, compared half a cycle later
    always @(negedge clk) begin
        if (chk_q2) begin
            check_eq(test_name, exp_q2, rgb);
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        bright     = 1'b0;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_jump   = 1'b0;
        map_sel    = 1'b0;
        h_count    = '0;
        v_count    = '0;
        exp_now    = '0;
        exp_q1     = '0;
        exp_q2     = '0;
        chk_now    = 1'b0;
        chk_q1     = 1'b0;
        chk_q2     = 1'b0;
        model_x    = `HERO_X_INIT;
        model_y    = `GROUND_Y - `HERO_SIZE;
        model_mask[0] = '0;
        model_mask[1] = '0;
        rng        = 32'd91;
        test_name  = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        check_eq("score after reset", 32'd0, score);
        check_eq("rgb after reset", 32'd0, rgb);
        test_name = "blanking";
        for (int i = 0; i < 8; i++) begin
            drive_pixel(100 + 37 * i, 50 + 29 * i, 1'b0, 1'b0);
        end
        drain_pixels();

        check_scene("static scene", 200);

        // walking on map 0, one pixel right then back to x 299
        map_sel   = 1'b0;
        btn_right = 1'b1;
        wait_for_hero("hero never reached h 332 while walking right", 332, 440, 1'b1);
        btn_right = 1'b0;
        btn_left  = 1'b1;
        wait_for_hero("hero never reached h 299 while walking left", 299, 440, 1'b1);
        btn_left  = 1'b0;
        model_x   = 299;

        // held for one step period so exactly one step sees it
        btn_jump    = 1'b1;
        repeat (STEP_DIV) next_cycle();
        btn_jump    = 1'b0;
        wait_for_hero("hero never left the ground after the jump", 315, 440, 1'b0);
        wait_for_hero("hero never came back down from the jump", 315, 440, 1'b1);
        wait_for_hero("hero never settled on the ground", 315, 459, 1'b1);
        check_eq("score after jump", 32'd0, score);

        // coin 3 of map 0 is first touched at x 329, that step moves the hero to 330
        test_name = "coins";
        btn_right = 1'b1;
        wait_for_score("score never reached 1 walking right on map 0", 16'd1);
        btn_right = 1'b0;
        model_x   = 330;
        mark_coin(1'b0, 329, model_y);
        h_count = coord_t'(368);
        v_count = coord_t'(452);
        bright  = 1'b1;
        repeat (2) next_cycle();
        check_eq("coin 3 of map 0 gone", 32'd1, (rgb == `SKY_RGB) || (rgb == `HERO_RGB));

        // coin 3 of map 1 is first touched at x 255
        map_sel  = 1'b1;
        btn_left = 1'b1;
        wait_for_score("score never reached 2 walking left on map 1", 16'd2);
        btn_left = 1'b0;
        model_x  = 254;
        mark_coin(1'b1, 255, model_y);

        check_scene("scene after coins", 200);

        if (u_game_top.u_checker.assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/game_pkg.sv
hw/scene_if.sv
hw/hero_motion.sv
hw/coin_tracker.sv
hw/scene_render.sv
hw/game_top.sv
verification/game_checker.sv
verification/game_tb.sv

//--- Bender.yml
package:
  name: platform_game

sources:
  - include_dirs:
      - hw
    files:
      - hw/game_pkg.sv
      - hw/scene_if.sv
      - hw/hero_motion.sv
      - hw/coin_tracker.sv
      - hw/scene_render.sv
      - hw/game_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/game_checker.sv
      - verification/game_tb.sv
